//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing
TOP       := tbPwmUnit
FILELIST  := tb.f
OBJDIR    := obj_dir

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

//--- pwmFifo.sv
`timescale 1ns/1ps

module pwmFifo (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 push,
	input  logic                 pop,
	input  s32xPwmPkg::pwWidth_t pushData,
	output s32xPwmPkg::pwWidth_t head,
	output logic                 full,
	output logic                 empty
);
	import s32xPwmPkg::*;

	typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

	pwWidth_t mem [FIFO_DEPTH];
	ptr_t     wrPtr;
	ptr_t     rdPtr;
	cnt_t     count;
	logic     doPush;
	logic     doPop;

	assign full   = (count == cnt_t'(FIFO_DEPTH));
	assign empty  = (count == '0);
	assign doPop  = pop && !empty;
	assign doPush = push && (!full || doPop);    // Full but draining this cycle
	assign head   = mem[rdPtr];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

//--- pwmRegs.sv
`timescale 1ns/1ps

module pwmRegs (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  logic                            pSel,
	input  logic                            pEnable,
	input  logic                            pWrite,
	input  logic [s32xPwmPkg::ADDR_W-1:0]   pAddr,
	input  logic [s32xPwmPkg::DATA_W-1:0]   pWData,
	output logic [s32xPwmPkg::DATA_W-1:0]   pRData,
	output logic                            pReady,
	output logic                            pSlvErr,
	input  logic                            intSet,
	input  logic                            fullL,
	input  logic                            emptyL,
	input  logic                            fullR,
	input  logic                            emptyR,
	output logic                            pushL,
	output logic                            pushR,
	output s32xPwmPkg::pwWidth_t            pushData,
	output s32xPwmPkg::pwWidth_t            cycle,
	output logic [s32xPwmPkg::TM_W-1:0]     tmInterval,
	output logic [1:0]                      chanEn,
	output logic                            mono,
	output logic                            rtp,
	output logic                            cycleRestart,
	output logic                            irq
);
	import s32xPwmPkg::*;

	logic [DATA_W-1:0] pwmcr;
	pwWidth_t          cycr;
	logic              access;
	logic              addrOk;
	logic              wrEn;
	logic [DATA_W-1:0] rData;

	assign pReady = 1'b1;    // No wait states
	assign access = pSel && pEnable && pReady;
	assign wrEn   = access && pWrite && addrOk;

	always_comb begin
		case (pAddr)
			REG_PWMCR, REG_CYCR, REG_LPWR, REG_RPWR, REG_MONOWR, REG_INTCLR: addrOk = 1'b1;
			default: addrOk = 1'b0;
		endcase
	end

	always_comb begin
		rData = '0;
		case (pAddr)
			REG_PWMCR: rData = pwmcr & PWMCR_MASK;
			REG_CYCR:  rData = {{(DATA_W-PW_W){1'b0}}, cycr};
			REG_LPWR: begin
				rData[FULL_BIT]  = fullL;
				rData[EMPTY_BIT] = emptyL;
			end
			REG_RPWR, REG_MONOWR: begin    // Mono reports the right FIFO
				rData[FULL_BIT]  = fullR;
				rData[EMPTY_BIT] = emptyR;
			end
			REG_INTCLR: rData[0] = irq;
			default: rData = '0;
		endcase
	end

	assign pRData  = rData;
	assign pSlvErr = access && !addrOk;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pwmcr        <= '0;
			cycr         <= '0;
			irq          <= 1'b0;
			pushL        <= 1'b0;
			pushR        <= 1'b0;
			cycleRestart <= 1'b0;
		end else begin
			pushL        <= wrEn && (pAddr == REG_LPWR || pAddr == REG_MONOWR);
			pushR        <= wrEn && (pAddr == REG_RPWR || pAddr == REG_MONOWR);
			cycleRestart <= wrEn && (pAddr == REG_PWMCR || pAddr == REG_CYCR);
			if (wrEn && pAddr == REG_PWMCR)
				pwmcr <= pWData & PWMCR_MASK;
			if (wrEn && pAddr == REG_CYCR)
				cycr <= pWData[PW_W-1:0];
			if (intSet)
				irq <= 1'b1;    // Set wins over a clear in the same cycle
			else if (wrEn && pAddr == REG_INTCLR)
				irq <= 1'b0;
		end
	end

	// Width travels with the push strobe
	always_ff @(posedge CLK) begin
		if (wrEn)
			pushData <= pWData[PW_W-1:0];
	end

	assign cycle      = cycr;
	assign tmInterval = pwmcr[TM_LSB +: TM_W];
	assign chanEn     = {pwmcr[RMD_BIT], pwmcr[LMD_BIT]};
	assign mono       = pwmcr[MONO_BIT];
	assign rtp        = pwmcr[RTP_BIT];

endmodule

//--- pwmSampleOut.sv
`timescale 1ns/1ps

module pwmSampleOut (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 tick,
	input  logic                 mono,
	input  s32xPwmPkg::pwWidth_t cycle,
	input  s32xPwmPkg::pwWidth_t headL,
	input  s32xPwmPkg::pwWidth_t headR,
	input  logic                 emptyL,
	input  logic                 emptyR,
	output s32xPwmPkg::sample_t  sampleL,
	output s32xPwmPkg::sample_t  sampleR
);
	import s32xPwmPkg::*;

	pwWidth_t latL;
	pwWidth_t latR;
	logic     validL;
	logic     validR;

	// Width to signed sample, centred on half the period
	function automatic sample_t convert(input pwWidth_t w, input pwWidth_t cyc);
		pwWidth_t half;
		pwWidth_t res;
		half = cyc >> 1;
		if (w == '0)
			res = '0;
		else if (w > cyc)
			res = half;
		else
			res = w - half;
		if (cyc[PW_W-1])
			return {res, {(DATA_W-PW_W){1'b0}}};
		return {res[PW_W-1], res[PW_W-3:0], 5'b00000};    // Drop bit 10 on short periods
	endfunction

	// Stage 1
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			validL <= 1'b0;
			validR <= 1'b0;
		end else begin
			validL <= tick && (mono ? !emptyR : !emptyL);
			validR <= tick && !emptyR;
		end
	end

	always_ff @(posedge CLK) begin
		if (tick) begin
			latL <= mono ? headR : headL;
			latR <= headR;
		end
	end

	// Stage 2
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sampleL <= '0;
			sampleR <= '0;
		end else begin
			if (validL)
				sampleL <= convert(latL, cycle);
			if (validR)
				sampleR <= convert(latR, cycle);
		end
	end

endmodule

//--- pwmTimer.sv
`timescale 1ns/1ps

module pwmTimer (
	input  logic                        CLK,
	input  logic                        RST_N,
	input  s32xPwmPkg::pwWidth_t        cycle,
	input  logic [s32xPwmPkg::TM_W-1:0] tmInterval,
	input  logic [1:0]                  chanEn,
	input  logic                        rtp,
	input  logic                        cycleRestart,
	output logic                        tick,
	output logic                        intSet,
	output logic                        dreq
);
	import s32xPwmPkg::*;

	pwWidth_t        cycCnt;
	logic [TM_W-1:0] tmCnt;
	logic [TM_W-1:0] tmLast;
	logic            run;

	// Stopped on zero period or with both channels off
	assign run = (cycle != '0) && (|chanEn);

	// TM of zero behaves as one
	assign tmLast = (tmInterval == '0) ? '0 : tmInterval - 1'b1;

	// No tick in the restart cycle
	assign tick   = run && !cycleRestart && (cycCnt == cycle);
	assign intSet = tick && (tmCnt == tmLast);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt <= '0;
		end else if (cycleRestart || !run) begin
			cycCnt <= '0;
		end else if (tick) begin
			cycCnt <= pwWidth_t'(1);    // Next period starts counting at one
		end else begin
			cycCnt <= cycCnt + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tmCnt <= '0;
		end else if (cycleRestart || !run) begin
			tmCnt <= '0;
		end else if (tick) begin
			if (tmCnt == tmLast)
				tmCnt <= '0;
			else
				tmCnt <= tmCnt + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			dreq <= 1'b0;
		else
			dreq <= intSet && rtp;
	end

endmodule

//--- pwmUnit.sv
`timescale 1ns/1ps

module pwmUnit (
	input  logic                          CLK,
	input  logic                          RST_N,
	input  logic                          pSel,
	input  logic                          pEnable,
	input  logic                          pWrite,
	input  logic [s32xPwmPkg::ADDR_W-1:0] pAddr,
	input  logic [s32xPwmPkg::DATA_W-1:0] pWData,
	output logic [s32xPwmPkg::DATA_W-1:0] pRData,
	output logic                          pReady,
	output logic                          pSlvErr,
	output s32xPwmPkg::sample_t           sampleL,
	output s32xPwmPkg::sample_t           sampleR,
	output logic                          irq,
	output logic                          dreq
);
	import s32xPwmPkg::*;

	logic            pushL;
	logic            pushR;
	pwWidth_t        pushData;
	pwWidth_t        cycle;
	logic [TM_W-1:0] tmInterval;
	logic [1:0]      chanEn;
	logic            mono;
	logic            rtp;
	logic            cycleRestart;
	logic            tick;
	logic            intSet;
	pwWidth_t        headL;
	pwWidth_t        headR;
	logic            fullL;
	logic            emptyL;
	logic            fullR;
	logic            emptyR;

	pwmRegs regs_i (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.pSel         (pSel),
		.pEnable      (pEnable),
		.pWrite       (pWrite),
		.pAddr        (pAddr),
		.pWData       (pWData),
		.pRData       (pRData),
		.pReady       (pReady),
		.pSlvErr      (pSlvErr),
		.intSet       (intSet),
		.fullL        (fullL),
		.emptyL       (emptyL),
		.fullR        (fullR),
		.emptyR       (emptyR),
		.pushL        (pushL),
		.pushR        (pushR),
		.pushData     (pushData),
		.cycle        (cycle),
		.tmInterval   (tmInterval),
		.chanEn       (chanEn),
		.mono         (mono),
		.rtp          (rtp),
		.cycleRestart (cycleRestart),
		.irq          (irq)
	);

	// Both FIFOs pop on every tick, empty ones ignore it
	pwmFifo fifoL_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.push     (pushL),
		.pop      (tick),
		.pushData (pushData),
		.head     (headL),
		.full     (fullL),
		.empty    (emptyL)
	);

	pwmFifo fifoR_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.push     (pushR),
		.pop      (tick),
		.pushData (pushData),
		.head     (headR),
		.full     (fullR),
		.empty    (emptyR)
	);

	pwmTimer timer_i (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.cycle        (cycle),
		.tmInterval   (tmInterval),
		.chanEn       (chanEn),
		.rtp          (rtp),
		.cycleRestart (cycleRestart),
		.tick         (tick),
		.intSet       (intSet),
		.dreq         (dreq)
	);

	pwmSampleOut out_i (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.tick    (tick),
		.mono    (mono),
		.cycle   (cycle),
		.headL   (headL),
		.headR   (headR),
		.emptyL  (emptyL),
		.emptyR  (emptyR),
		.sampleL (sampleL),
		.sampleR (sampleR)
	);

endmodule

//--- s32xPwmPkg.sv
package s32xPwmPkg;

	// Datapath widths
	localparam int PW_W       = 12;
	localparam int DATA_W     = 16;
	localparam int ADDR_W     = 4;
	localparam int FIFO_DEPTH = 3;
	localparam int TM_W       = 4;

	typedef logic [PW_W-1:0]   pwWidth_t;
	typedef logic [DATA_W-1:0] sample_t;

	// Register byte offsets
	localparam logic [ADDR_W-1:0] REG_PWMCR  = 4'd0;
	localparam logic [ADDR_W-1:0] REG_CYCR   = 4'd2;
	localparam logic [ADDR_W-1:0] REG_LPWR   = 4'd4;
	localparam logic [ADDR_W-1:0] REG_RPWR   = 4'd6;
	localparam logic [ADDR_W-1:0] REG_MONOWR = 4'd8;
	localparam logic [ADDR_W-1:0] REG_INTCLR = 4'd10;

	// PWMCR fields
	localparam int LMD_BIT  = 0;    // Left channel enable
	localparam int RMD_BIT  = 1;    // Right channel enable
	localparam int MONO_BIT = 4;
	localparam int RTP_BIT  = 7;    // DMA request on timer
	localparam int TM_LSB   = 8;    // Timer interval 11..8

	// Bits 11..8, 7, 4, 1, 0
	localparam logic [DATA_W-1:0] PWMCR_MASK = 16'h0F93;

	// Width register status bits
	localparam int FULL_BIT  = 15;
	localparam int EMPTY_BIT = 14;

endpackage

//--- tb.f
s32xPwmPkg.sv
pwmRegs.sv
pwmFifo.sv
pwmTimer.sv
pwmSampleOut.sv
pwmUnit.sv
tbPwmUnit.sv

//--- tbPwmUnit.sv
`timescale 1ns/1ps

module tbPwmUnit;
	import s32xPwmPkg::*;

	localparam int TIMEOUT = 6000;    // About 4000 cycles of tests plus margin

	logic              CLK;
	logic              RST_N;
	logic              pSel;
	logic              pEnable;
	logic              pWrite;
	logic [ADDR_W-1:0] pAddr;
	logic [DATA_W-1:0] pWData;
	logic [DATA_W-1:0] pRData;
	logic              pReady;
	logic              pSlvErr;
	sample_t           sampleL;
	sample_t           sampleR;
	logic              irq;
	logic              dreq;

	int   cycles = 0;
	int   errCount;
	logic wrErr;    // pSlvErr of the last write

	pwmUnit dut_i (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.pSel    (pSel),
		.pEnable (pEnable),
		.pWrite  (pWrite),
		.pAddr   (pAddr),
		.pWData  (pWData),
		.pRData  (pRData),
		.pReady  (pReady),
		.pSlvErr (pSlvErr),
		.sampleL (sampleL),
		.sampleR (sampleR),
		.irq     (irq),
		.dreq    (dreq)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("TESTBENCH FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic failNow(input string msg);
		errCount++;
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		if (got !== exp)
			failNow($sformatf("mismatch at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic checkSample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp)
			failNow($sformatf("mismatch at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			failNow($sformatf("mismatch at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// Signed sample from a width centred on half the period
	function automatic sample_t expectSample(input pwWidth_t w, input pwWidth_t cyc);
		int       half;
		int       diff;
		pwWidth_t res;
		half = int'(cyc) / 2;
		if (w == 12'd0)
			diff = 0;
		else if (int'(w) > int'(cyc))
			diff = half;
		else
			diff = int'(w) - half;
		res = pwWidth_t'(diff);
		if (cyc >= 12'd2048)
			return {res, 4'h0};
		return {res[11], res[9:0], 5'b00000};
	endfunction

	function automatic pwWidth_t randWidth(input pwWidth_t c);
		return pwWidth_t'($urandom % (32'(c) + 32'd2));    // 0 up to one above CYCR
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic apbWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge CLK);
		#1;
		pSel    = 1'b1;
		pEnable = 1'b0;
		pWrite  = 1'b1;
		pAddr   = addr;
		pWData  = data;
		@(posedge CLK);
		#1;
		pEnable = 1'b1;
		@(negedge CLK);
		wrErr = pSlvErr;
		@(posedge CLK);    // Write lands here
		#1;
		pSel    = 1'b0;
		pEnable = 1'b0;
		pWrite  = 1'b0;
	endtask

	task automatic apbRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
			output logic err);
		@(posedge CLK);
		#1;
		pSel    = 1'b1;
		pEnable = 1'b0;
		pWrite  = 1'b0;
		pAddr   = addr;
		@(posedge CLK);
		#1;
		pEnable = 1'b1;
		@(negedge CLK);
		checkBit(pReady, 1'b1, "pReady");
		data = pRData;
		err  = pSlvErr;
		@(posedge CLK);
		#1;
		pSel    = 1'b0;
		pEnable = 1'b0;
	endtask

	task automatic readExpect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
			input string what);
		logic [DATA_W-1:0] d;
		logic              e;
		apbRead(addr, d, e);
		checkBit(e, 1'b0, {what, " pSlvErr"});
		checkWord(d, exp, what);
	endtask

	// Samples irq and counts dreq pulses once per clock
	task automatic watchTimer(input int n, output logic irqSeen, output int dreqCount);
		int k;
		irqSeen   = 1'b0;
		dreqCount = 0;
		for (k = 0; k < n; k++) begin
			waitCycles(1);
			if (irq)
				irqSeen = 1'b1;
			if (dreq)
				dreqCount++;
		end
	endtask

	task automatic checkResetState();
		checkBit(irq, 1'b0, "irq after reset");
		checkBit(dreq, 1'b0, "dreq after reset");
		checkBit(pSlvErr, 1'b0, "pSlvErr after reset");
		checkSample(sampleL, '0, "sampleL after reset");
		checkSample(sampleR, '0, "sampleR after reset");
		readExpect(REG_PWMCR, 16'h0000, "PWMCR after reset");
		readExpect(REG_CYCR, 16'h0000, "CYCR after reset");
		readExpect(REG_LPWR, 16'h4000, "LPWR after reset");
		readExpect(REG_RPWR, 16'h4000, "RPWR after reset");
		readExpect(REG_MONOWR, 16'h4000, "MONOWR after reset");
		readExpect(REG_INTCLR, 16'h0000, "INTCLR after reset");
		apbWrite(REG_PWMCR, 16'hFFFF);
		readExpect(REG_PWMCR, 16'h0F93, "PWMCR writable bits");
		apbWrite(REG_CYCR, 16'hFFFF);
		readExpect(REG_CYCR, 16'h0FFF, "CYCR writable bits");
		apbWrite(REG_PWMCR, 16'h0000);
		apbWrite(REG_CYCR, 16'h0000);
	endtask

	task automatic fifoFullTest();
		pwWidth_t w [4];
		pwWidth_t c;
		int       i;
		c = 12'd20;
		apbWrite(REG_CYCR, {4'h0, c});
		for (i = 0; i < 3; i++)
			w[i] = pwWidth_t'(32'd1 + $urandom % 32'd19);
		w[3] = w[2] + 12'd1;    // Differs from the last kept entry
		for (i = 0; i < 4; i++)
			apbWrite(REG_LPWR, {4'h0, w[i]});
		readExpect(REG_LPWR, 16'h8000, "LPWR status when full");
		readExpect(REG_RPWR, 16'h4000, "RPWR status with no pushes");
		readExpect(REG_MONOWR, 16'h4000, "MONOWR status follows right FIFO");
		apbWrite(REG_PWMCR, 16'h0001);    // Left only
		for (i = 0; i < 4; i++) begin
			waitCycles((i == 0) ? int'(c) + 4 : int'(c));
			checkSample(sampleL, expectSample(w[(i < 3) ? i : 2], c), "sampleL while draining");
			checkSample(sampleR, '0, "sampleR with empty FIFO");
		end
		readExpect(REG_LPWR, 16'h4000, "LPWR status after drain");
		apbWrite(REG_PWMCR, 16'h0000);
	endtask

	task automatic stereoTest(input pwWidth_t c, input int n);
		pwWidth_t wl [3];
		pwWidth_t wr [3];
		int       i;
		apbWrite(REG_PWMCR, 16'h0000);
		apbWrite(REG_CYCR, {4'h0, c});
		for (i = 0; i < n; i++) begin
			wl[i] = randWidth(c);
			wr[i] = randWidth(c);
		end
		if (n == 3) begin
			wl[0] = 12'd0;
			wr[0] = c + 12'd1;
			wl[1] = c + 12'd1;
			wr[2] = 12'd0;
		end
		for (i = 0; i < n; i++) begin
			apbWrite(REG_LPWR, {4'h0, wl[i]});
			apbWrite(REG_RPWR, {4'h0, wr[i]});
		end
		apbWrite(REG_PWMCR, 16'h0003);
		for (i = 0; i < n; i++) begin
			waitCycles((i == 0) ? int'(c) + 4 : int'(c));
			checkSample(sampleL, expectSample(wl[i], c), "stereo sampleL");
			checkSample(sampleR, expectSample(wr[i], c), "stereo sampleR");
		end
		apbWrite(REG_PWMCR, 16'h0000);
	endtask

	task automatic monoTest();
		pwWidth_t m [2];
		pwWidth_t c;
		int       i;
		c = 12'd100;
		m[0] = randWidth(c);
		m[1] = randWidth(c);
		apbWrite(REG_CYCR, {4'h0, c});
		// Extra left entry must never reach the outputs
		apbWrite(REG_LPWR, {4'h0, randWidth(c)});
		apbWrite(REG_MONOWR, {4'h0, m[0]});
		apbWrite(REG_MONOWR, {4'h0, m[1]});
		readExpect(REG_LPWR, 16'h8000, "LPWR status after mono pushes");
		readExpect(REG_RPWR, 16'h0000, "RPWR status after mono pushes");
		apbWrite(REG_PWMCR, 16'h0013);
		for (i = 0; i < 3; i++) begin
			waitCycles((i == 0) ? int'(c) + 4 : int'(c));
			checkSample(sampleL, expectSample(m[(i == 0) ? 0 : 1], c), "mono sampleL");
			checkSample(sampleR, expectSample(m[(i == 0) ? 0 : 1], c), "mono sampleR");
		end
		apbWrite(REG_PWMCR, 16'h0000);
	endtask

	task automatic irqTest();
		pwWidth_t c;
		int       dreqCount;
		logic     irqSeen;
		c = 12'd100;
		apbWrite(REG_PWMCR, 16'h0000);
		apbWrite(REG_CYCR, {4'h0, c});
		apbWrite(REG_INTCLR, 16'h0000);
		checkBit(irq, 1'b0, "irq before timer test");
		apbWrite(REG_PWMCR, 16'h0003);    // TM 0 acts as one, no DMA request
		watchTimer(int'(c) + 4, irqSeen, dreqCount);
		if (!irqSeen)
			failNow("irq did not rise within one timer period with TM at zero");
		if (dreqCount != 0)
			failNow($sformatf("mismatch at time %0t: %0d dreq pulses, expected 0",
				$time, dreqCount));
		apbWrite(REG_PWMCR, 16'h0000);
		apbWrite(REG_INTCLR, 16'h0000);
		checkBit(irq, 1'b0, "irq after first INTCLR write");
		apbWrite(REG_PWMCR, 16'h0383);    // TM 3, RTP, both channels
		watchTimer(3 * int'(c) + 4, irqSeen, dreqCount);
		if (!irqSeen)
			failNow("irq did not rise within three timer periods");
		if (dreqCount != 1)
			failNow($sformatf("mismatch at time %0t: %0d dreq pulses, expected 1",
				$time, dreqCount));
		apbWrite(REG_INTCLR, 16'hFFFF);
		checkBit(irq, 1'b0, "irq after INTCLR write");
		readExpect(REG_INTCLR, 16'h0000, "INTCLR after clear");
		apbWrite(REG_PWMCR, 16'h0000);
	endtask

	// Interrupt flag is still set from the mono run
	task automatic badAddrTest();
		logic [DATA_W-1:0] d;
		logic              e;
		apbWrite(REG_CYCR, 16'h0123);
		apbWrite(REG_PWMCR, 16'h0590);    // No channel enabled
		apbWrite(4'd14, 16'hFFFF);
		checkBit(wrErr, 1'b1, "pSlvErr on write to offset 14");
		apbRead(4'd14, d, e);
		checkBit(e, 1'b1, "pSlvErr on read of offset 14");
		checkWord(d, 16'h0000, "read data of offset 14");
		readExpect(REG_PWMCR, 16'h0590, "PWMCR after bad access");
		readExpect(REG_CYCR, 16'h0123, "CYCR after bad access");
		readExpect(REG_LPWR, 16'h4000, "LPWR after bad access");
		readExpect(REG_RPWR, 16'h4000, "RPWR after bad access");
		readExpect(REG_INTCLR, 16'h0001, "INTCLR after bad access");
	endtask

	initial begin
		CLK      = 1'b0;
		RST_N    = 1'b0;
		pSel     = 1'b0;
		pEnable  = 1'b0;
		pWrite   = 1'b0;
		pAddr    = '0;
		pWData   = '0;
		errCount = 0;
		wrErr    = 1'b0;
		void'($urandom(32'hfc0f55df));
		repeat (10) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		checkResetState();
		fifoFullTest();
		stereoTest(12'd100, 3);
		stereoTest(12'd2100, 1);    // Long period with bit 11 set
		monoTest();
		badAddrTest();
		irqTest();
		if (errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
